//--- dv/bank_mem_model.sv
`timescale 1ns/1ps

module bank_mem_model import xfer_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 v_i,
  input  logic                                 grant_i,
  input  logic                                 w_i,
  input  bank_addr_t                           addr_i,
  input  beat_t                                data_i,
  input  logic [ways-1:0][beat_mask_width-1:0] w_mask_i,
  output beat_t [ways-1:0]                     rd_data_o
);

  localparam int rows = sets * bursts_per_bank;

  beat_t mem [ways][rows];

  // background pattern from way and row, so a stale read never looks like line data
  initial begin
    rd_data_o = '0;
    for (int w = 0; w < ways; w++) begin
      for (int r = 0; r < rows; r++) begin
        mem[w][r] = {16'hdead, 8'(w), 8'(r), 16'hbeef, 8'(r), 8'(w)};
      end
    end
  end

  // one access per granted request, reads return all ways a cycle later
  always @(posedge clk_i) begin
    if (v_i && grant_i) begin
      for (int w = 0; w < ways; w++) begin
        if (w_i) begin
          for (int b = 0; b < beat_mask_width; b++) begin
            if (w_mask_i[w][b]) begin
              mem[w][addr_i][8*b +: 8] <= data_i[8*b +: 8];
            end
          end
        end else begin
          rd_data_o[w] <= mem[w][addr_i];
        end
      end
    end
  end

endmodule

//--- dv/tb_evict_fill_transmitter.sv
`timescale 1ns/1ps

module tb_evict_fill_transmitter import xfer_pkg::*; ();

  localparam int   num_cmds       = 10;
  localparam int   timeout_cycles = num_cmds * 200;
  localparam logic evict_op       = 1'b0;
  localparam logic refill_op      = 1'b1;

  logic clk = 1'b0;
  logic reset;
  logic evict_we;
  logic refill_we;
  way_t way;
  set_t addr_index;

  logic                                 even_grant = 1'b0;
  logic                                 odd_grant = 1'b0;
  beat_t [ways-1:0]                     even_rd;
  beat_t [ways-1:0]                     odd_rd;
  logic                                 even_v;
  logic                                 even_w;
  bank_addr_t                           even_addr;
  beat_t                                even_wdata;
  logic [ways-1:0][beat_mask_width-1:0] even_mask;
  logic                                 odd_v;
  logic                                 odd_w;
  bank_addr_t                           odd_addr;
  beat_t                                odd_wdata;
  logic [ways-1:0][beat_mask_width-1:0] odd_mask;

  refill_pair_u refill_data = '0;
  logic         dma_refill_v = 1'b0;
  logic         dma_refill_ready;
  logic         dma_evict_v;
  beat_t        dma_evict_data;
  logic         dma_evict_yumi = 1'b0;
  logic         evict_done;
  logic         refill_done;
  logic         evict_busy;
  logic         refill_busy;
  logic         even_prio;
  logic         odd_prio;

  // command table
  logic [8*16-1:0] name_tbl [num_cmds];
  logic            op_tbl [num_cmds];
  way_t            way_tbl [num_cmds];
  set_t            set_tbl [num_cmds];
  logic [15:0]     seed_tbl [num_cmds];
  logic            throttle_tbl [num_cmds];
  int              tbl_fill = 0;

  logic [8*16-1:0] cur_name = '0;
  logic            cur_throttle = 1'b0;
  // throttle mode of the running command, taken at the clock edge
  logic            throttle_now = 1'b0;
  beat_t [3:0]     cur_line = '0;
  logic [1:0]      pair_idx = '0;
  logic [15:0]     lfsr = 16'd51402;
  logic            yumi_bit = 1'b0;
  logic            refill_bit = 1'b0;
  int              value_errs;
  int              proto_errs;
  int              cycle_cnt;

  always #2 clk = ~clk;

  evict_fill_transmitter i_dut (
    .clk_i (clk), .reset_i (reset),
    .evict_we_i (evict_we), .refill_we_i (refill_we),
    .way_i (way), .addr_index_i (addr_index),
    .even_bank_v_i (even_grant), .even_bank_data_i (even_rd),
    .even_bank_v_o (even_v), .even_bank_w_o (even_w), .even_bank_addr_o (even_addr),
    .even_bank_data_o (even_wdata), .even_bank_w_mask_o (even_mask),
    .odd_bank_v_i (odd_grant), .odd_bank_data_i (odd_rd),
    .odd_bank_v_o (odd_v), .odd_bank_w_o (odd_w), .odd_bank_addr_o (odd_addr),
    .odd_bank_data_o (odd_wdata), .odd_bank_w_mask_o (odd_mask),
    .dma_refill_data_i (refill_data), .dma_refill_v_i (dma_refill_v),
    .dma_refill_ready_o (dma_refill_ready),
    .dma_evict_v_o (dma_evict_v), .dma_evict_data_o (dma_evict_data),
    .dma_evict_yumi_i (dma_evict_yumi),
    .evict_done_o (evict_done), .refill_done_o (refill_done),
    .evict_busy_o (evict_busy), .refill_busy_o (refill_busy),
    .even_priority_o (even_prio), .odd_priority_o (odd_prio)
  );

  bank_mem_model i_even_mem (
    .clk_i (clk), .v_i (even_v), .grant_i (even_grant), .w_i (even_w),
    .addr_i (even_addr), .data_i (even_wdata), .w_mask_i (even_mask), .rd_data_o (even_rd)
  );

  bank_mem_model i_odd_mem (
    .clk_i (clk), .v_i (odd_v), .grant_i (odd_grant), .w_i (odd_w),
    .addr_i (odd_addr), .data_i (odd_wdata), .w_mask_i (odd_mask), .rd_data_o (odd_rd)
  );

  xfer_checker i_checker (
    .clk_i (clk), .reset_i (reset),
    .name_i (cur_name), .way_i (way), .set_i (addr_index), .line_i (cur_line),
    .evict_we_i (evict_we), .refill_we_i (refill_we),
    .bank_v_i ({odd_v, even_v}), .grant_i ({odd_grant, even_grant}),
    .bank_w_i ({odd_w, even_w}), .bank_addr_i ({odd_addr, even_addr}),
    .bank_data_i ({odd_wdata, even_wdata}), .bank_w_mask_i ({odd_mask, even_mask}),
    .dma_refill_ready_i (dma_refill_ready), .dma_evict_v_i (dma_evict_v),
    .dma_evict_yumi_i (dma_evict_yumi), .dma_evict_data_i (dma_evict_data),
    .done_i ({refill_done, evict_done}), .busy_i ({refill_busy, evict_busy}),
    .priority_i ({odd_prio, even_prio}),
    .value_errs_o (value_errs), .proto_errs_o (proto_errs)
  );

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic random_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b = lfsr[0];
  endtask

  // beat p holds words 2p (low half) and 2p+1
  function automatic beat_t line_beat(input logic [15:0] seed, input set_t set_idx, input int p);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = 8'(2 * p);
    hi = 8'(2 * p + 1);
    return {seed ^ {8'h00, hi}, 4'h0, set_idx, hi, seed ^ {8'h00, lo}, 4'h0, set_idx, lo};
  endfunction

  task automatic add_cmd(input logic [8*16-1:0] name, input logic op, input way_t w,
                         input set_t s, input logic [15:0] seed, input logic throttle);
    name_tbl[tbl_fill] = name;
    op_tbl[tbl_fill] = op;
    way_tbl[tbl_fill] = w;
    set_tbl[tbl_fill] = s;
    seed_tbl[tbl_fill] = seed;
    throttle_tbl[tbl_fill] = throttle;
    tbl_fill++;
  endtask

  task automatic end_run(input logic timed_out);
    $display("errors: %0d value mismatches, %0d protocol", value_errs, proto_errs);
    if (timed_out || (value_errs + proto_errs) != 0) begin
      $display("=== FAIL ===");
    end else begin
      $display("=== PASS ===");
    end
    $finish;
  endtask

  // DMA and bank arbiter model that withholds at random for throttled commands
  always @(posedge clk) begin
    throttle_now = cur_throttle;
    if (refill_we) begin
      pair_idx = '0;
    end else if (dma_refill_v && dma_refill_ready) begin
      pair_idx = pair_idx + 1'b1;
    end
    #0.5;
    if (throttle_now) begin
      random_bit(even_grant);
      random_bit(odd_grant);
      random_bit(yumi_bit);
      random_bit(refill_bit);
    end else begin
      even_grant = 1'b1;
      odd_grant = 1'b1;
      yumi_bit = 1'b1;
      refill_bit = 1'b1;
    end
    dma_evict_yumi = dma_evict_v & yumi_bit;
    dma_refill_v = refill_busy & (pair_idx < 2'd2) & refill_bit;
    // the DMA sends the pair as one word, beat 2p in the low half
    if (dma_refill_v) begin
      refill_data.flat = {cur_line[2*pair_idx[0] + 1], cur_line[2*pair_idx[0]]};
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, no done pulse for %0s", cycle_cnt, cur_name);
    end_run(1'b1);
  end

  initial begin
    reset = 1'b1;
    evict_we = 1'b0;
    refill_we = 1'b0;
    way = '0;
    addr_index = '0;
    add_cmd("refill_w0_s3", refill_op, 1'b0, 4'd3, 16'ha1b2, 1'b0);
    add_cmd("evict_w0_s3", evict_op, 1'b0, 4'd3, 16'ha1b2, 1'b0);
    add_cmd("refill_w1_s3", refill_op, 1'b1, 4'd3, 16'h5c6d, 1'b1);
    add_cmd("evict_w0_kept", evict_op, 1'b0, 4'd3, 16'ha1b2, 1'b1);
    add_cmd("evict_w1_s3", evict_op, 1'b1, 4'd3, 16'h5c6d, 1'b1);
    add_cmd("refill_w1_s15", refill_op, 1'b1, 4'd15, 16'h0f0f, 1'b1);
    add_cmd("refill_w0_s0", refill_op, 1'b0, 4'd0, 16'h3344, 1'b1);
    add_cmd("evict_w1_s15", evict_op, 1'b1, 4'd15, 16'h0f0f, 1'b1);
    add_cmd("evict_w0_s0", evict_op, 1'b0, 4'd0, 16'h3344, 1'b0);
    add_cmd("evict_w1_s3_b", evict_op, 1'b1, 4'd3, 16'h5c6d, 1'b1);
    repeat (2) @(posedge clk);
    #0.5;
    reset = 1'b0;
    for (int i = 0; i < num_cmds; i++) begin
      @(posedge clk);
      #0.5;
      cur_name = name_tbl[i];
      cur_throttle = throttle_tbl[i];
      for (int p = 0; p < 4; p++) begin
        cur_line[p] = line_beat(seed_tbl[i], set_tbl[i], p);
      end
      way = way_tbl[i];
      addr_index = set_tbl[i];
      evict_we = (op_tbl[i] == evict_op);
      refill_we = (op_tbl[i] == refill_op);
      @(posedge clk);
      #0.5;
      evict_we = 1'b0;
      refill_we = 1'b0;
      do begin
        @(posedge clk);
      end while (!((op_tbl[i] == refill_op) ? refill_done : evict_done));
    end
    repeat (2) @(posedge clk);
    end_run(1'b0);
  end

endmodule

//--- dv/xfer_checker.sv
`timescale 1ns/1ps

module xfer_checker import xfer_pkg::*; (
  input  logic                                      clk_i,
  input  logic                                      reset_i,

  // command now being run by the sequence
  input  logic [8*16-1:0]                           name_i,
  input  way_t                                      way_i,
  input  set_t                                      set_i,
  input  beat_t [3:0]                               line_i,

  // DUT ports, bank index 0 is the even bank
  input  logic                                      evict_we_i,
  input  logic                                      refill_we_i,
  input  logic [1:0]                                bank_v_i,
  input  logic [1:0]                                grant_i,
  input  logic [1:0]                                bank_w_i,
  input  bank_addr_t [1:0]                          bank_addr_i,
  input  beat_t [1:0]                               bank_data_i,
  input  logic [1:0][ways-1:0][beat_mask_width-1:0] bank_w_mask_i,
  input  logic                                      dma_refill_ready_i,
  input  logic                                      dma_evict_v_i,
  input  logic                                      dma_evict_yumi_i,
  input  beat_t                                     dma_evict_data_i,
  // index 0 evict, index 1 refill
  input  logic [1:0]                                done_i,
  input  logic [1:0]                                busy_i,
  // index 0 even hint, index 1 odd hint
  input  logic [1:0]                                priority_i,

  output int                                        value_errs_o,
  output int                                        proto_errs_o
);

  logic                                 reset_q = 1'b0;
  logic                                 active;
  logic                                 refill_cmd;
  logic [1:0][2:0]                      acc_cnt;
  logic [1:0]                           pend;
  logic [2:0]                           beat_cnt;
  logic [1:0]                           complete;
  logic [ways-1:0][beat_mask_width-1:0] exp_mask;

  initial begin
    value_errs_o = 0;
    proto_errs_o = 0;
  end

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      value_errs_o++;
      $display("[FAIL] %0s: %0s expected %h actual %h", name_i, what, exp, act);
    end
  endtask

  task automatic complain(input string msg);
    proto_errs_o++;
    $display("error in %0s: %0s", name_i, msg);
  endtask

  // a bank is finished once both bursts are done and no read is still returning
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      complete[b] = (acc_cnt[b] == 3'd2) && !pend[b];
    end
    exp_mask          = '0;
    exp_mask[way_i]   = '1;
  end

  always @(posedge clk_i) begin
    reset_q <= reset_i;
    if (reset_i) begin
      active     <= 1'b0;
      refill_cmd <= 1'b0;
      acc_cnt    <= '0;
      pend       <= '0;
      beat_cnt   <= '0;
    end else begin
      if (reset_q) begin
        compare("reset state", '0, {bank_v_i, bank_w_i, dma_refill_ready_i, dma_evict_v_i,
                                    done_i, busy_i, priority_i});
      end
      compare("evict busy", active & ~refill_cmd, busy_i[0]);
      compare("refill busy", active & refill_cmd, busy_i[1]);
      compare("even priority", complete[1] & ~complete[0], priority_i[0]);
      compare("odd priority", complete[0] & ~complete[1], priority_i[1]);

      for (int k = 0; k < 2; k++) begin
        if (done_i[k] && !(active && (refill_cmd == k[0]))) begin
          complain("done pulse with no matching command");
        end
      end
      if (active && done_i[refill_cmd]) begin
        if (refill_cmd) begin
          compare("even bank writes", 2, acc_cnt[0]);
          compare("odd bank writes", 2, acc_cnt[1]);
        end else begin
          compare("evict beat count", 4, beat_cnt);
        end
        active <= 1'b0;
      end

      if (evict_we_i || refill_we_i) begin
        active     <= 1'b1;
        refill_cmd <= refill_we_i;
        acc_cnt    <= '0;
        pend       <= '0;
        beat_cnt   <= '0;
      end else begin
        for (int b = 0; b < 2; b++) begin
          if (bank_v_i[b]) begin
            compare("bank write enable", active & refill_cmd, bank_w_i[b]);
          end
          if (bank_v_i[b] && grant_i[b]) begin
            compare("bank row", set_i * 2 + acc_cnt[b], bank_addr_i[b]);
            if (bank_w_i[b]) begin
              compare("bank write data", line_i[2*acc_cnt[b] + b], bank_data_i[b]);
              compare("bank write mask", exp_mask, bank_w_mask_i[b]);
            end
            acc_cnt[b] <= acc_cnt[b] + 1'b1;
          end
          pend[b] <= active & ~refill_cmd & bank_v_i[b] & grant_i[b];
        end
        if (dma_evict_v_i && dma_evict_yumi_i) begin
          if (!active || refill_cmd) begin
            complain("evict beat taken outside an evict");
          end
          compare($sformatf("evict beat %0d", beat_cnt), line_i[beat_cnt], dma_evict_data_i);
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- evict_fill_transmitter.f
verilog/xfer_pkg.sv
verilog/xfer_cmd_reg.sv
verilog/bank_channel.sv
verilog/evict_serializer.sv
verilog/evict_fill_transmitter.sv
dv/bank_mem_model.sv
dv/xfer_checker.sv
dv/tb_evict_fill_transmitter.sv

//--- verilog/bank_channel.sv
`timescale 1ns/1ps

module bank_channel import xfer_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 reset_i,

  input  logic                                 evict_en_i,
  input  logic                                 refill_en_i,
  input  way_t                                 way_i,
  input  set_t                                 set_i,

  // bank side
  input  logic                                 grant_i,
  input  beat_t [ways-1:0]                     bank_data_i,
  output logic                                 bank_v_o,
  output logic                                 bank_w_o,
  output bank_addr_t                           bank_addr_o,
  output beat_t                                bank_data_o,
  output logic [ways-1:0][beat_mask_width-1:0] bank_w_mask_o,

  // refill half from the DMA
  input  logic                                 fill_push_i,
  input  beat_t                                fill_data_i,

  // FIFO head toward the serializer
  input  logic                                 pop_i,
  output logic                                 head_v_o,
  output beat_t                                head_data_o,

  output logic                                 room_o,
  output logic                                 done_o
);

  localparam int ptr_width = $clog2(bursts_per_bank);

  beat_t                mem_r [bursts_per_bank];
  logic [ptr_width-1:0] wr_ptr_r;
  logic [ptr_width-1:0] rd_ptr_r;
  burst_cnt_t           fifo_cnt_r;
  burst_cnt_t           burst_cnt_r;
  logic                 pend_r;

  logic                 access;
  logic                 push;
  logic                 pop;
  beat_t                push_data;
  logic [2:0]           evict_total;
  logic [2:0]           fill_total;
  logic                 cnt_done;

  assign cnt_done    = (burst_cnt_r == burst_cnt_t'(bursts_per_bank));
  assign evict_total = fifo_cnt_r + pend_r;
  assign fill_total  = burst_cnt_r + fifo_cnt_r;

  // evict reads need a free slot for every read still in flight
  assign bank_v_o = (evict_en_i & ~cnt_done & (evict_total < bursts_per_bank))
                  | (refill_en_i & head_v_o);
  assign bank_w_o = refill_en_i;
  assign access   = bank_v_o & grant_i;

  assign bank_addr_o = bank_row(set_i, burst_cnt_r);
  assign bank_data_o = head_data_o;

  always_comb begin
    for (int w = 0; w < ways; w++) begin
      bank_w_mask_o[w] = {beat_mask_width{way_i == way_t'(w)}};
    end
  end

  // read data returns one cycle after the granted read
  assign push      = pend_r | fill_push_i;
  assign push_data = evict_en_i ? bank_data_i[way_i] : fill_data_i;

  // refill drains through its own bank writes
  assign pop = evict_en_i ? pop_i : access;

  assign head_v_o    = (fifo_cnt_r != '0);
  assign head_data_o = mem_r[rd_ptr_r];

  // never take more than one line worth of refill data
  assign room_o = (fill_total < bursts_per_bank);
  assign done_o = cnt_done & ~pend_r;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= push_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      fifo_cnt_r <= '0;
      pend_r     <= 1'b0;
    end else begin
      pend_r <= evict_en_i & access;
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   fifo_cnt_r <= fifo_cnt_r + 1'b1;
        2'b01:   fifo_cnt_r <= fifo_cnt_r - 1'b1;
        default: fifo_cnt_r <= fifo_cnt_r;
      endcase
    end
  end

  // burst counter, cleared once the command has finished and the enables are gone
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      burst_cnt_r <= '0;
    end else if (done_o & ~evict_en_i & ~refill_en_i) begin
      burst_cnt_r <= '0;
    end else if (access) begin
      burst_cnt_r <= burst_cnt_r + 1'b1;
    end
  end

  // a read issued last cycle must still find a free slot
  a_fifo_no_overflow: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (push && !pop) |-> (fifo_cnt_r < burst_cnt_t'(bursts_per_bank))
  );

endmodule

//--- verilog/evict_fill_transmitter.sv
`timescale 1ns/1ps

module evict_fill_transmitter import xfer_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 reset_i,

  // command start
  input  logic                                 evict_we_i,
  input  logic                                 refill_we_i,
  input  way_t                                 way_i,
  input  set_t                                 addr_index_i,

  // even bank
  input  logic                                 even_bank_v_i,
  input  beat_t [ways-1:0]                     even_bank_data_i,
  output logic                                 even_bank_v_o,
  output logic                                 even_bank_w_o,
  output bank_addr_t                           even_bank_addr_o,
  output beat_t                                even_bank_data_o,
  output logic [ways-1:0][beat_mask_width-1:0] even_bank_w_mask_o,

  // odd bank
  input  logic                                 odd_bank_v_i,
  input  beat_t [ways-1:0]                     odd_bank_data_i,
  output logic                                 odd_bank_v_o,
  output logic                                 odd_bank_w_o,
  output bank_addr_t                           odd_bank_addr_o,
  output beat_t                                odd_bank_data_o,
  output logic [ways-1:0][beat_mask_width-1:0] odd_bank_w_mask_o,

  // DMA refill, ready/valid
  input  refill_pair_u                         dma_refill_data_i,
  input  logic                                 dma_refill_v_i,
  output logic                                 dma_refill_ready_o,

  // DMA evict, valid/yumi
  output logic                                 dma_evict_v_o,
  output beat_t                                dma_evict_data_o,
  input  logic                                 dma_evict_yumi_i,

  // status
  output logic                                 evict_done_o,
  output logic                                 refill_done_o,
  output logic                                 evict_busy_o,
  output logic                                 refill_busy_o,
  output logic                                 even_priority_o,
  output logic                                 odd_priority_o
);

  logic  evict_en;
  logic  refill_en;
  way_t  way_r;
  set_t  set_r;

  logic  even_head_v;
  logic  odd_head_v;
  beat_t even_head_data;
  beat_t odd_head_data;
  logic  even_room;
  logic  odd_room;
  logic  even_done;
  logic  odd_done;

  logic  ser_pop;
  logic  ser_empty;
  logic  fill_push;

  xfer_cmd_reg i_cmd_reg (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .evict_we_i    (evict_we_i),
    .refill_we_i   (refill_we_i),
    .way_i         (way_i),
    .addr_index_i  (addr_index_i),
    .evict_done_i  (evict_done_o),
    .refill_done_i (refill_done_o),
    .evict_en_o    (evict_en),
    .refill_en_o   (refill_en),
    .way_o         (way_r),
    .set_o         (set_r)
  );

  // a refill pair enters both FIFOs together
  assign dma_refill_ready_o = refill_en & even_room & odd_room;
  assign fill_push          = dma_refill_v_i & dma_refill_ready_o;

  bank_channel i_even_chan (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .evict_en_i    (evict_en),
    .refill_en_i   (refill_en),
    .way_i         (way_r),
    .set_i         (set_r),
    .grant_i       (even_bank_v_i),
    .bank_data_i   (even_bank_data_i),
    .bank_v_o      (even_bank_v_o),
    .bank_w_o      (even_bank_w_o),
    .bank_addr_o   (even_bank_addr_o),
    .bank_data_o   (even_bank_data_o),
    .bank_w_mask_o (even_bank_w_mask_o),
    .fill_push_i   (fill_push),
    .fill_data_i   (dma_refill_data_i.half[0]),
    .pop_i         (ser_pop),
    .head_v_o      (even_head_v),
    .head_data_o   (even_head_data),
    .room_o        (even_room),
    .done_o        (even_done)
  );

  bank_channel i_odd_chan (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .evict_en_i    (evict_en),
    .refill_en_i   (refill_en),
    .way_i         (way_r),
    .set_i         (set_r),
    .grant_i       (odd_bank_v_i),
    .bank_data_i   (odd_bank_data_i),
    .bank_v_o      (odd_bank_v_o),
    .bank_w_o      (odd_bank_w_o),
    .bank_addr_o   (odd_bank_addr_o),
    .bank_data_o   (odd_bank_data_o),
    .bank_w_mask_o (odd_bank_w_mask_o),
    .fill_push_i   (fill_push),
    .fill_data_i   (dma_refill_data_i.half[1]),
    .pop_i         (ser_pop),
    .head_v_o      (odd_head_v),
    .head_data_o   (odd_head_data),
    .room_o        (odd_room),
    .done_o        (odd_done)
  );

  evict_serializer i_serializer (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .evict_en_i       (evict_en),
    .even_v_i         (even_head_v),
    .odd_v_i          (odd_head_v),
    .even_data_i      (even_head_data),
    .odd_data_i       (odd_head_data),
    .pop_o            (ser_pop),
    .dma_evict_v_o    (dma_evict_v_o),
    .dma_evict_data_o (dma_evict_data_o),
    .dma_evict_yumi_i (dma_evict_yumi_i),
    .empty_o          (ser_empty)
  );

  // evict is finished only once every beat has left toward the DMA
  assign evict_done_o  = evict_en & even_done & odd_done
                       & ~even_head_v & ~odd_head_v & ser_empty;
  assign refill_done_o = refill_en & even_done & odd_done;

  assign evict_busy_o  = evict_en;
  assign refill_busy_o = refill_en;

  // favour the bank that still has bursts left
  assign even_priority_o = odd_done & ~even_done;
  assign odd_priority_o  = even_done & ~odd_done;

endmodule

//--- verilog/evict_serializer.sv
`timescale 1ns/1ps

module evict_serializer import xfer_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,

  input  logic  evict_en_i,

  // bank FIFO heads
  input  logic  even_v_i,
  input  logic  odd_v_i,
  input  beat_t even_data_i,
  input  beat_t odd_data_i,
  output logic  pop_o,

  // DMA evict port
  output logic  dma_evict_v_o,
  output beat_t dma_evict_data_o,
  input  logic  dma_evict_yumi_i,

  output logic  empty_o
);

  beat_t [1:0] pair_r;
  logic        full_r;
  logic        sel_r;

  // take a pair only when both heads are there and the register is free
  assign pop_o = evict_en_i & even_v_i & odd_v_i & ~full_r;

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      pair_r[0] <= even_data_i;
      pair_r[1] <= odd_data_i;
    end
  end

  // sel_r picks the even beat first, then the odd one
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
      sel_r  <= 1'b0;
    end else if (pop_o) begin
      full_r <= 1'b1;
      sel_r  <= 1'b0;
    end else if (full_r & dma_evict_yumi_i) begin
      if (sel_r) begin
        full_r <= 1'b0;
        sel_r  <= 1'b0;
      end else begin
        sel_r <= 1'b1;
      end
    end
  end

  assign dma_evict_v_o    = full_r;
  assign dma_evict_data_o = pair_r[sel_r];
  assign empty_o          = ~full_r;

  // an offered beat stays put until the DMA takes it
  a_evict_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (dma_evict_v_o && !dma_evict_yumi_i) |=> (dma_evict_v_o && $stable(dma_evict_data_o))
  );

endmodule

//--- verilog/xfer_cmd_reg.sv
`timescale 1ns/1ps

module xfer_cmd_reg import xfer_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,

  input  logic evict_we_i,
  input  logic refill_we_i,
  input  way_t way_i,
  input  set_t addr_index_i,

  input  logic evict_done_i,
  input  logic refill_done_i,

  output logic evict_en_o,
  output logic refill_en_o,
  output way_t way_o,
  output set_t set_o
);

  // operation flags, held from the start pulse until the matching done
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      evict_en_o  <= 1'b0;
      refill_en_o <= 1'b0;
    end else begin
      if (evict_we_i) begin
        evict_en_o <= 1'b1;
      end else if (evict_done_i) begin
        evict_en_o <= 1'b0;
      end

      if (refill_we_i) begin
        refill_en_o <= 1'b1;
      end else if (refill_done_i) begin
        refill_en_o <= 1'b0;
      end
    end
  end

  // line being moved
  always_ff @(posedge clk_i) begin
    if (evict_we_i | refill_we_i) begin
      way_o <= way_i;
      set_o <= addr_index_i;
    end
  end

  // a new command only while idle, and one kind at a time
  a_start_when_idle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (evict_we_i | refill_we_i) |-> !(evict_en_o | refill_en_o) && !(evict_we_i && refill_we_i)
  );

  // the evict and refill datapaths share the bank FIFOs
  a_one_operation: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(evict_en_o && refill_en_o)
  );

endmodule

//--- verilog/xfer_pkg.sv
package xfer_pkg;

  // data sizes
  localparam int word_width      = 32;
  localparam int beat_width      = 2 * word_width;
  localparam int beat_mask_width = beat_width / 8;

  // cache geometry, each bank holds half of an 8-word line
  localparam int bursts_per_bank = 2;
  localparam int ways            = 2;
  localparam int sets            = 16;

  typedef logic [$clog2(ways)-1:0]                 way_t;
  typedef logic [$clog2(sets)-1:0]                 set_t;
  typedef logic [$clog2(sets*bursts_per_bank)-1:0] bank_addr_t;

  // counts 0..bursts_per_bank, the top value marks the bank as finished
  typedef logic [$clog2(bursts_per_bank+1)-1:0]    burst_cnt_t;

  typedef logic [beat_width-1:0] beat_t;

  // two-beat refill word
  // flat for the DMA side, half[0] goes to the even bank and half[1] to the odd bank
  typedef union packed {
    logic [2*beat_width-1:0] flat;
    beat_t [1:0]             half;
  } refill_pair_u;

  // bank row of one beat within a set
  function automatic bank_addr_t bank_row(set_t set_idx, burst_cnt_t burst);
    bank_addr_t row;
    row = bank_addr_t'(set_idx * bursts_per_bank + burst);
    return row;
  endfunction

endpackage
